// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cdc_pkt_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/cdc_pkt_checker.sv ====
module cdc_pkt_checker
    import afifo_pkg::*;
#(
    parameter int unsigned DATA_W = 16,
    parameter int unsigned ADDR_W = 3
) (
    input logic                     rst_,
    input logic                     w_clk,
    input logic                     r_clk,
    input logic                     wr_push,
    input logic                     wr_ready,
    input logic [ADDR_W:0]          wr_bin,
    input logic                     rd_en,
    input logic                     rd_pop,
    input logic                     rd_ready,
    input logic [ADDR_W:0]          rd_bin,
    input logic [DATA_W+OP_W-1:0]   rd_word
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned DEPTH = 1 << ADDR_W;

    // One sticky flag per property
    logic bad_write = 1'b0;
    logic bad_read  = 1'b0;
    logic bad_hold  = 1'b0;
    logic bad_reset = 1'b0;
    logic [ADDR_W:0] fill;      // True occupancy from both raw pointers
    logic fired;

    assign fill  = wr_bin - rd_bin;
    assign fired = bad_write | bad_read | bad_hold | bad_reset;

    // A push never lands on a FIFO that is really full
    a_no_write_full: assert property (@(posedge w_clk) disable iff (!rst_)
        wr_push |-> fill < DEPTH)
    else begin
        $error("FIFO write accepted while the FIFO was full");
        bad_write = 1'b1;
    end

    a_no_read_empty: assert property (@(posedge r_clk) disable iff (!rst_)
        rd_pop |-> fill != '0)
    else begin
        $error("FIFO read accepted while the FIFO was empty");
        bad_read = 1'b1;
    end

    // Head word must not change until it is popped
    a_rd_word_hold: assert property (@(posedge r_clk) disable iff (!rst_)
        rd_ready && !rd_en |=> $stable(rd_word))
    else begin
        $error("FIFO head word changed without a read");
        bad_hold = 1'b1;
    end

    a_reset_flags: assert property (@(posedge r_clk)
        $rose(rst_) |-> wr_ready && !rd_ready)
    else begin
        $error("FIFO flags wrong right after reset");
        bad_reset = 1'b1;
    end

endmodule

// ==== dv/cdc_pkt_tb.sv ====
module cdc_pkt_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          DATA_W      = 16;
    localparam int          ADDR_W      = 3;
    localparam int          MAX_PKT_LEN = 6;
    localparam int          SUM_W       = DATA_W + 8;
    localparam int          NUM_PKTS    = 30;
    localparam int          TIMEOUT_CYC = NUM_PKTS * 10 * 40;
    localparam int unsigned SEED        = 32'h74546e20;

    logic              w_clk     = 1'b0;
    logic              r_clk     = 1'b0;
    logic              rst_      = 1'b0;
    logic              in_valid  = 1'b0;
    logic [DATA_W-1:0] in_data   = '0;
    logic              in_last   = 1'b0;
    logic              in_ready;
    logic              out_ready = 1'b0;
    logic              out_valid;
    logic [SUM_W-1:0]  out_count;
    logic [SUM_W-1:0]  out_sum;

    // Expected results, written in w_clk order and read in r_clk order
    logic [SUM_W-1:0]  exp_count [256];
    logic [SUM_W-1:0]  exp_sum [256];
    int                wr_idx    = 0;
    int                rd_idx    = 0;
    int                chk_idx;
    int                run_count = 0;
    logic [SUM_W-1:0]  run_sum   = '0;
    int                cycle_cnt = 0;
    logic              hold_out  = 1'b0;
    string             test_name = "reset";

    always #20 r_clk = ~r_clk;
    always #14 w_clk = ~w_clk;      // Producer side runs faster

    cdc_pkt_top #(
        .DATA_W      (DATA_W),
        .ADDR_W      (ADDR_W),
        .MAX_PKT_LEN (MAX_PKT_LEN),
        .SUM_W       (SUM_W)
    ) u_dut (.*);

    bind async_fifo cdc_pkt_checker #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_checker (.*);

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic send_packet(input int len);
        int gap;
        for (int i = 0; i < len; i++) begin
            in_valid <= 1'b1;
            in_data  <= DATA_W'($urandom);
            in_last  <= (i == len - 1);
            @(posedge w_clk);
            while (!in_ready) begin
                @(posedge w_clk);
            end
            in_valid <= 1'b0;
            in_last  <= 1'b0;
            gap = $urandom_range(2, 0);
            repeat (gap) @(posedge w_clk);
        end
    endtask

    // Wait until every expected result was checked, then realign to w_clk
    task automatic wait_drain();
        repeat (2) @(posedge w_clk);
        while (rd_idx != wr_idx) begin
            @(posedge r_clk);
        end
        @(posedge w_clk);
    endtask

    // ======================================================================
    // Reference model and result check
    // ======================================================================
    always @(posedge w_clk) begin
        if (rst_ && in_valid && in_ready) begin
            run_count = run_count + 1;
            run_sum   = run_sum + SUM_W'(in_data);     // Wraps at SUM_W
            if (in_last || run_count == MAX_PKT_LEN) begin
                exp_count[wr_idx] = SUM_W'(run_count);
                exp_sum[wr_idx]   = run_sum;
                wr_idx    = wr_idx + 1;
                run_count = 0;
                run_sum   = '0;
            end
        end
    end

    always @(posedge r_clk) begin
        if (rst_ && out_valid && out_ready) begin
            if (rd_idx == wr_idx) begin
                fail_stop("A packet result came out with no input packet behind it");
            end else begin
                chk_idx = rd_idx;
                rd_idx  = rd_idx + 1;
                assert (out_count == exp_count[chk_idx] && out_sum == exp_sum[chk_idx])
                    else fail_stop($sformatf(
                        "[FAIL] %s expected count %0d sum 0x%0h, actual count %0d sum 0x%0h",
                        test_name, exp_count[chk_idx], exp_sum[chk_idx], out_count, out_sum));
            end
        end
    end

    // Sink stalls, long hold during the back-pressure test
    always @(posedge r_clk) begin
        if (hold_out) begin
            out_ready <= 1'b0;
        end else begin
            out_ready <= ($urandom_range(3, 0) != 0);
        end
    end

    always @(posedge r_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (u_dut.u_fifo.u_checker.fired) begin
            fail_stop("A FIFO assertion in the bound checker failed");
        end else if (cycle_cnt >= TIMEOUT_CYC) begin
            fail_stop($sformatf("Timeout in %s: the run did not finish in %0d r_clk cycles",
                                test_name, TIMEOUT_CYC));
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        void'($urandom(SEED));
        repeat (3) @(posedge r_clk);
        assert (in_ready && !out_valid && !u_dut.wr_en && !u_dut.rd_en)
            else fail_stop($sformatf(
                "[FAIL] %s expected in_ready/out_valid/wr_en/rd_en 1000, actual %b%b%b%b",
                test_name, in_ready, out_valid, u_dut.wr_en, u_dut.rd_en));
        rst_ <= 1'b1;
        @(posedge w_clk);

        test_name = "integrity";
        repeat (20) send_packet($urandom_range(5, 1));
        wait_drain();

        test_name = "split";          // Longer than MAX_PKT_LEN
        repeat (6) send_packet($urandom_range(9, 7));
        wait_drain();

        test_name = "backpressure";
        hold_out = 1'b1;
        fork
            repeat (4) send_packet(5);
            begin
                while (in_ready) begin
                    @(posedge w_clk);
                end
                repeat (100) @(posedge w_clk);     // FIFO sits full here
                hold_out = 1'b0;
            end
        join
        wait_drain();

        repeat (20) @(posedge r_clk);
        if (rd_idx == wr_idx && !out_valid) begin
            $display("test passed");
            $finish;
        end else begin
            fail_stop("Results were left over after the last packet");
        end
    end

endmodule

// ==== rtl/afifo_pkg.sv ====
package afifo_pkg;

    // ======================================================================
    // Word tag stored beside each data word in the FIFO
    // ======================================================================
    typedef enum logic [0:0] {
        OP_DATA = 1'b0,     // Packet continues
        OP_LAST = 1'b1      // Closes the packet
    } word_op_e;

    // Tag width, stored word is DATA_W + OP_W bits
    localparam int unsigned OP_W = 1;

    // ======================================================================
    // Consumer FSM states
    // ======================================================================
    typedef enum logic [0:0] {
        ST_ACCUM = 1'b0,    // Popping and summing words
        ST_EMIT  = 1'b1     // Result held for the sink
    } sum_state_e;

endpackage

// ==== rtl/async_fifo.sv ====
module async_fifo
    import afifo_pkg::*;
#(
    parameter int unsigned DATA_W = 16,
    parameter int unsigned ADDR_W = 3
) (
    input  logic                     rst_,
    input  logic                     w_clk,
    input  logic                     r_clk,
    // Write side
    input  logic                     wr_en,
    input  logic [DATA_W+OP_W-1:0]   wr_word,
    output logic                     wr_ready,
    // Read side
    input  logic                     rd_en,
    output logic [DATA_W+OP_W-1:0]   rd_word,
    output logic                     rd_ready
);

    // ======================================================================
    // Write domain
    // ======================================================================
    logic [ADDR_W:0] wr_bin;
    logic [ADDR_W:0] wr_gray;
    logic [ADDR_W:0] wr_bin_next;
    logic [ADDR_W:0] wr_gray_next;
    logic [ADDR_W:0] rd_gray;          // Owned by the read domain
    logic [ADDR_W:0] rd_gray_s1;       // Read pointer synchronizer
    logic [ADDR_W:0] rd_gray_s2;
    logic            wr_full;
    logic            wr_push;

    assign wr_push      = wr_en && !wr_full;
    assign wr_bin_next  = wr_bin + {{ADDR_W{1'b0}}, wr_push};
    assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

    always_ff @(posedge w_clk or negedge rst_) begin
        if (!rst_) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
            wr_full    <= 1'b0;
        end else begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_gray_next;
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            // Full when pointers differ only in the wrap bits
            wr_full    <= (wr_gray_next ==
                           {~rd_gray_s2[ADDR_W:ADDR_W-1], rd_gray_s2[ADDR_W-2:0]});
        end
    end

    assign wr_ready = !wr_full;

    // ======================================================================
    // Read domain
    // ======================================================================
    logic [ADDR_W:0] rd_bin;
    logic [ADDR_W:0] rd_bin_next;
    logic [ADDR_W:0] rd_gray_next;
    logic [ADDR_W:0] wr_gray_s1;       // Write pointer synchronizer
    logic [ADDR_W:0] wr_gray_s2;
    logic            rd_empty;
    logic            rd_pop;

    assign rd_pop       = rd_en && !rd_empty;
    assign rd_bin_next  = rd_bin + {{ADDR_W{1'b0}}, rd_pop};
    assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
            rd_empty   <= 1'b1;
        end else begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= rd_gray_next;
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            rd_empty   <= (rd_gray_next == wr_gray_s2);
        end
    end

    assign rd_ready = !rd_empty;

    // ======================================================================
    // Storage
    // ======================================================================
    // Read address runs one step ahead so rd_word is ready with rd_ready
    dp_ram #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_ram (
        .w_clk  (w_clk),
        .r_clk  (r_clk),
        .we     (wr_push),
        .waddr  (wr_bin[ADDR_W-1:0]),
        .wdata  (wr_word),
        .raddr  (rd_bin_next[ADDR_W-1:0]),
        .rdata  (rd_word)
    );

endmodule

// ==== rtl/cdc_pkt_top.sv ====
module cdc_pkt_top
    import afifo_pkg::*;
#(
    parameter int unsigned DATA_W      = 16,
    parameter int unsigned ADDR_W      = 3,
    parameter int unsigned MAX_PKT_LEN = 6,
    parameter int unsigned SUM_W       = DATA_W + 8
) (
    input  logic               w_clk,
    input  logic               r_clk,
    input  logic               rst_,
    // Input side, w_clk domain
    input  logic               in_valid,
    input  logic [DATA_W-1:0]  in_data,
    input  logic               in_last,
    output logic               in_ready,
    // Output side, r_clk domain
    input  logic               out_ready,
    output logic               out_valid,
    output logic [SUM_W-1:0]   out_count,
    output logic [SUM_W-1:0]   out_sum
);

    // ======================================================================
    // Internal links
    // ======================================================================
    logic                     wr_en;
    logic [DATA_W+OP_W-1:0]   wr_word;
    logic                     wr_ready;
    logic                     rd_en;
    logic [DATA_W+OP_W-1:0]   rd_word;
    logic                     rd_ready;

    pkt_tagger #(
        .DATA_W      (DATA_W),
        .MAX_PKT_LEN (MAX_PKT_LEN)
    ) u_tagger (
        .w_clk    (w_clk),
        .rst_     (rst_),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_last  (in_last),
        .in_ready (in_ready),
        .wr_ready (wr_ready),
        .wr_en    (wr_en),
        .wr_word  (wr_word)
    );

    // Clock crossing
    async_fifo #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_fifo (
        .rst_     (rst_),
        .w_clk    (w_clk),
        .r_clk    (r_clk),
        .wr_en    (wr_en),
        .wr_word  (wr_word),
        .wr_ready (wr_ready),
        .rd_en    (rd_en),
        .rd_word  (rd_word),
        .rd_ready (rd_ready)
    );

    pkt_summer #(
        .DATA_W (DATA_W),
        .SUM_W  (SUM_W)
    ) u_summer (
        .r_clk     (r_clk),
        .rst_      (rst_),
        .rd_word   (rd_word),
        .rd_ready  (rd_ready),
        .rd_en     (rd_en),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_count (out_count),
        .out_sum   (out_sum)
    );

endmodule

// ==== rtl/dp_ram.sv ====
module dp_ram
    import afifo_pkg::*;
#(
    parameter int unsigned DATA_W = 16,
    parameter int unsigned ADDR_W = 3
) (
    input  logic                     w_clk,
    input  logic                     r_clk,
    input  logic                     we,
    input  logic [ADDR_W-1:0]        waddr,
    input  logic [DATA_W+OP_W-1:0]   wdata,
    input  logic [ADDR_W-1:0]        raddr,
    output logic [DATA_W+OP_W-1:0]   rdata
);

    localparam int unsigned DEPTH = 1 << ADDR_W;

    logic [DATA_W+OP_W-1:0] mem [DEPTH];

    // Write port
    always_ff @(posedge w_clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge r_clk) begin
        rdata <= mem[raddr];    // Registered read
    end

endmodule

// ==== rtl/pkt_summer.sv ====
module pkt_summer
    import afifo_pkg::*;
#(
    parameter int unsigned DATA_W = 16,
    parameter int unsigned SUM_W  = 24
) (
    input  logic                     r_clk,
    input  logic                     rst_,
    // FIFO side
    input  logic [DATA_W+OP_W-1:0]   rd_word,
    input  logic                     rd_ready,
    output logic                     rd_en,
    // Result side
    input  logic                     out_ready,
    output logic                     out_valid,
    output logic [SUM_W-1:0]         out_count,
    output logic [SUM_W-1:0]         out_sum
);

    sum_state_e        state;
    logic [DATA_W-1:0] rd_data;
    word_op_e          rd_op;
    logic [SUM_W-1:0]  acc_count;
    logic [SUM_W-1:0]  acc_sum;
    logic [SUM_W-1:0]  next_count;
    logic [SUM_W-1:0]  next_sum;
    logic              pop_last;

    // Split the stored word
    assign rd_data = rd_word[DATA_W-1:0];
    assign rd_op   = word_op_e'(rd_word[DATA_W +: OP_W]);

    assign rd_en      = (state == ST_ACCUM) && rd_ready;   // One pop per cycle
    assign pop_last   = rd_en && (rd_op == OP_LAST);
    assign next_count = acc_count + SUM_W'(1);
    assign next_sum   = acc_sum + SUM_W'(rd_data);         // Wraps at SUM_W
    assign out_valid  = (state == ST_EMIT);

    // ======================================================================
    // FSM and accumulators
    // ======================================================================
    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            state     <= ST_ACCUM;
            acc_count <= '0;
            acc_sum   <= '0;
        end else begin
            case (state)
                ST_ACCUM: begin
                    if (pop_last) begin
                        acc_count <= '0;
                        acc_sum   <= '0;
                        state     <= ST_EMIT;
                    end else if (rd_en) begin
                        acc_count <= next_count;
                        acc_sum   <= next_sum;
                    end
                end
                ST_EMIT: begin
                    // No pops until the sink takes the result
                    if (out_ready) begin
                        state <= ST_ACCUM;
                    end
                end
                default: state <= ST_ACCUM;
            endcase
        end
    end

    // Result latch includes the last word
    always_ff @(posedge r_clk) begin
        if (pop_last) begin
            out_count <= next_count;
            out_sum   <= next_sum;
        end
    end

endmodule

// ==== rtl/pkt_tagger.sv ====
module pkt_tagger
    import afifo_pkg::*;
#(
    parameter int unsigned DATA_W      = 16,
    parameter int unsigned MAX_PKT_LEN = 6
) (
    input  logic                     w_clk,
    input  logic                     rst_,
    // Input side
    input  logic                     in_valid,
    input  logic [DATA_W-1:0]        in_data,
    input  logic                     in_last,
    output logic                     in_ready,
    // FIFO side
    input  logic                     wr_ready,
    output logic                     wr_en,
    output logic [DATA_W+OP_W-1:0]   wr_word
);

    localparam int unsigned CNT_W = $clog2(MAX_PKT_LEN + 1);

    logic [CNT_W-1:0] word_cnt;     // Words already taken in this packet
    logic             accept;
    logic             tag_last;
    word_op_e         tag_op;

    // Register free now or draining this cycle
    assign in_ready = !wr_en || wr_ready;
    assign accept   = in_valid && in_ready;

    // Close on a marked last word or at the length limit
    assign tag_last = in_last || (word_cnt == CNT_W'(MAX_PKT_LEN - 1));
    assign tag_op   = tag_last ? OP_LAST : OP_DATA;

    // ======================================================================
    // Control
    // ======================================================================
    always_ff @(posedge w_clk or negedge rst_) begin
        if (!rst_) begin
            wr_en    <= 1'b0;
            word_cnt <= '0;
        end else begin
            if (accept) begin
                wr_en    <= 1'b1;
                word_cnt <= tag_last ? '0 : word_cnt + CNT_W'(1);
            end else if (wr_ready) begin
                wr_en    <= 1'b0;       // Word went into the FIFO
            end
        end
    end

    // Payload
    always_ff @(posedge w_clk) begin
        if (accept) begin
            wr_word <= {tag_op, in_data};
        end
    end

endmodule

// ==== sim.f ====
rtl/afifo_pkg.sv
rtl/dp_ram.sv
rtl/async_fifo.sv
rtl/pkt_tagger.sv
rtl/pkt_summer.sv
rtl/cdc_pkt_top.sv
dv/cdc_pkt_checker.sv
dv/cdc_pkt_tb.sv
